// File: hw/socBusPkg.sv
`default_nettype none

package socBusPkg;

    // Wishbone word and byte-lane select
    typedef logic [31:0] wbData_t;
    typedef logic [3:0]  wbSel_t;

    // Register index inside one 4 KB peripheral slot
    typedef logic [9:0]  regIndex_t;

    // ------------------------------------------------------------------------
    // Address views
    // ------------------------------------------------------------------------

    // SRAM side reads the address as a word offset into the region
    typedef struct packed {
        logic [3:0]  region;
        logic [25:0] wordIndex;
        logic [1:0]  byteOffset;
    } busMemView_t;

    // Peripheral side splits the low half into slot and register
    typedef struct packed {
        logic [3:0]  region;
        logic [11:0] spare;
        logic [3:0]  slot;
        regIndex_t   regIndex;
        logic [1:0]  byteOffset;
    } busPeriphView_t;

    typedef union packed {
        busMemView_t    mem;
        busPeriphView_t periph;
    } busAddr_u;

endpackage

`default_nettype wire

// File: hw/socMapPkg.sv
`default_nettype none

package socMapPkg;

    // ------------------------------------------------------------------------
    // Regions, address bits 31..28
    // ------------------------------------------------------------------------
    localparam logic [3:0] RegionTcm    = 4'd2;
    localparam logic [3:0] RegionPeriph = 4'd4;

    // Peripheral slots, address bits 15..12
    localparam logic [3:0] SlotGpio    = 4'd0;
    localparam logic [3:0] SlotSysCtrl = 4'd1;

    // ------------------------------------------------------------------------
    // Register indices
    // ------------------------------------------------------------------------

    // Key/LED block
    localparam socBusPkg::regIndex_t RegLed       = 10'd0;
    localparam socBusPkg::regIndex_t RegKeyStatus = 10'd1;
    localparam socBusPkg::regIndex_t RegIrqEnable = 10'd2;
    localparam socBusPkg::regIndex_t RegIrqClear  = 10'd3;

    // System control block
    localparam socBusPkg::regIndex_t RegId       = 10'd0;
    localparam socBusPkg::regIndex_t RegScratch  = 10'd1;
    localparam socBusPkg::regIndex_t RegIrqRaw   = 10'd2;
    localparam socBusPkg::regIndex_t RegResetReq = 10'd3;

    // Read-only identification word
    localparam logic [31:0] SocId = 32'h4D335F31;

endpackage

`default_nettype wire

// File: hw/busDecoder.sv
`default_nettype none
`timescale 1ns/1ps

module busDecoder #(
    parameter int TcmAddrWidth = 10
) (
    input  logic               clk,
    input  logic               sysRstn,
    input  logic               wbCyc,
    input  logic               wbStb,
    input  socBusPkg::busAddr_u wbAdr,
    output logic               tcmStb,
    output logic               periphStb,
    input  socBusPkg::wbData_t tcmDatR,
    input  socBusPkg::wbData_t periphDatR,
    input  logic               tcmAck,
    input  logic               periphAck,
    input  logic               periphErr,
    output socBusPkg::wbData_t wbDatR,
    output logic               wbAck,
    output logic               wbErr
);
    import socMapPkg::*;

    logic reqValid;
    logic tcmHit;
    logic periphHit;
    logic unmapped;
    logic errReg;

    assign reqValid = wbCyc & wbStb;

    // ------------------------------------------------------------------------
    // Region decode
    // ------------------------------------------------------------------------

    // Words past the end of the SRAM fall through to the error path
    assign tcmHit = (wbAdr.mem.region == RegionTcm)
                    && ((wbAdr.mem.wordIndex >> TcmAddrWidth) == '0);
    assign periphHit = wbAdr.mem.region == RegionPeriph;
    assign unmapped = reqValid & ~tcmHit & ~periphHit;

    // At most one target sees the strobe
    assign tcmStb = reqValid & tcmHit;
    assign periphStb = reqValid & periphHit;

    // One-cycle error for unmapped space, held off while already answering
    always_ff @(posedge clk or negedge sysRstn) begin
        if (!sysRstn) begin
            errReg <= 1'b0;
        end else begin
            errReg <= unmapped & ~errReg;
        end
    end

    // ------------------------------------------------------------------------
    // Response return
    // ------------------------------------------------------------------------
    assign wbAck = tcmAck | periphAck;
    assign wbErr = errReg | periphErr;
    assign wbDatR = tcmAck ? tcmDatR : periphDatR;

endmodule

`default_nettype wire

// File: hw/tcmSram.sv
`default_nettype none
`timescale 1ns/1ps

module tcmSram #(
    parameter int TcmAddrWidth = 10
) (
    input  logic               clk,
    input  logic               tcmStb,
    input  logic               wbWe,
    input  socBusPkg::busAddr_u wbAdr,
    input  socBusPkg::wbSel_t  wbSel,
    input  socBusPkg::wbData_t wbDatW,
    output socBusPkg::wbData_t tcmDatR,
    output logic               tcmAck,
    input  logic               sysRstn
);

    localparam int Depth = 2 ** TcmAddrWidth;

    logic [31:0] mem [Depth];

    logic [TcmAddrWidth-1:0] wordAddr;
    logic                    access;

    // Decoder already rejects indices beyond the array
    assign wordAddr = wbAdr.mem.wordIndex[TcmAddrWidth-1:0];

    // New request only when no response is on the bus
    assign access = tcmStb & ~tcmAck;

    always_ff @(posedge clk or negedge sysRstn) begin
        if (!sysRstn) begin
            tcmAck <= 1'b0;
        end else begin
            tcmAck <= access;
        end
    end

    // ------------------------------------------------------------------------
    // Storage with byte lanes
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (access && wbWe) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wbSel[lane]) begin
                    mem[wordAddr][lane*8 +: 8] <= wbDatW[lane*8 +: 8];
                end
            end
        end
    end

    // Read word lands together with the ack
    always_ff @(posedge clk) begin
        if (access) begin
            tcmDatR <= mem[wordAddr];
        end
    end

endmodule

`default_nettype wire

// File: hw/periphMux.sv
`default_nettype none
`timescale 1ns/1ps

module periphMux (
    input  logic               clk,
    input  logic               sysRstn,
    input  logic               periphStb,
    input  socBusPkg::busAddr_u wbAdr,
    output logic               gpioStb,
    output logic               sysStb,
    input  socBusPkg::wbData_t gpioDatR,
    input  socBusPkg::wbData_t sysDatR,
    input  logic               gpioAck,
    input  logic               sysAck,
    output socBusPkg::wbData_t periphDatR,
    output logic               periphAck,
    output logic               periphErr
);
    import socMapPkg::*;

    logic gpioSel;
    logic sysSel;
    logic slotMiss;

    // Slot from address bits 15..12
    assign gpioSel = wbAdr.periph.slot == SlotGpio;
    assign sysSel = wbAdr.periph.slot == SlotSysCtrl;

    assign gpioStb = periphStb & gpioSel;
    assign sysStb = periphStb & sysSel;
    assign slotMiss = periphStb & ~gpioSel & ~sysSel;

    // Empty slots answer with a one-cycle error
    always_ff @(posedge clk or negedge sysRstn) begin
        if (!sysRstn) begin
            periphErr <= 1'b0;
        end else begin
            periphErr <= slotMiss & ~periphErr;
        end
    end

    // AND-OR return path, only the acking leaf contributes
    assign periphAck = gpioAck | sysAck;
    assign periphDatR = ({32{gpioAck}} & gpioDatR)
                        | ({32{sysAck}} & sysDatR);

endmodule

`default_nettype wire

// File: hw/keyLedGpio.sv
`default_nettype none
`timescale 1ns/1ps

module keyLedGpio (
    input  logic                 clk,
    input  logic                 sysRstn,
    input  logic                 gpioStb,
    input  logic                 wbWe,
    input  socBusPkg::regIndex_t regIndex,
    input  socBusPkg::wbData_t   wbDatW,
    output socBusPkg::wbData_t   gpioDatR,
    output logic                 gpioAck,
    input  logic                 key,
    output logic [3:0]           ledOut,
    output logic                 keyIrq
);
    import socMapPkg::*;

    logic        access;
    logic        wrEn;
    logic        irqEnable;
    logic [1:0]  keySync;
    logic        keyPrev;
    logic        keyRise;
    logic        pending;
    logic        irqClear;
    logic [31:0] readData;

    assign access = gpioStb & ~gpioAck;
    assign wrEn = access & wbWe;

    assign keyRise = keySync[1] & ~keyPrev;
    assign irqClear = wrEn && (regIndex == RegIrqClear) && wbDatW[0];

    // ------------------------------------------------------------------------
    // Control registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge sysRstn) begin
        if (!sysRstn) begin
            gpioAck   <= 1'b0;
            ledOut    <= 4'b0;
            irqEnable <= 1'b0;
            keySync   <= 2'b0;
            keyPrev   <= 1'b0;
            pending   <= 1'b0;
            keyIrq    <= 1'b0;
        end else begin
            gpioAck <= access;
            if (wrEn && regIndex == RegLed) begin
                ledOut <= wbDatW[3:0];
            end
            if (wrEn && regIndex == RegIrqEnable) begin
                irqEnable <= wbDatW[0];
            end
            // Two-flop synchronizer, then edge register
            keySync <= {keySync[0], key};
            keyPrev <= keySync[1];
            // A new edge wins over a clear in the same cycle
            pending <= (pending & ~irqClear) | keyRise;
            keyIrq  <= pending & irqEnable;
        end
    end

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------
    always_comb begin
        case (regIndex)
            RegLed:       readData = {28'b0, ledOut};
            RegKeyStatus: readData = {30'b0, pending, keySync[1]};
            RegIrqEnable: readData = {31'b0, irqEnable};
            default:      readData = 32'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access) begin
            gpioDatR <= readData;
        end
    end

endmodule

`default_nettype wire

// File: hw/sysControl.sv
`default_nettype none
`timescale 1ns/1ps

module sysControl (
    input  logic                 clk,
    input  logic                 RSTn,
    input  logic                 sysStb,
    input  logic                 wbWe,
    input  socBusPkg::regIndex_t regIndex,
    input  socBusPkg::wbData_t   wbDatW,
    output socBusPkg::wbData_t   sysDatR,
    output logic                 sysAck,
    input  logic                 keyIrq,
    output logic                 sysRstn
);
    import socMapPkg::*;

    logic        access;
    logic        wrEn;
    logic        resetReq;
    logic [31:0] scratch;
    logic [31:0] readData;

    assign access = sysStb & ~sysAck;
    assign wrEn = access & wbWe;

    // ------------------------------------------------------------------------
    // Bus handshake and soft reset, on the board reset only
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            sysAck   <= 1'b0;
            resetReq <= 1'b0;
            sysRstn  <= 1'b0;
        end else begin
            sysAck   <= access;
            // Request lives for one cycle, reset follows it by one edge
            resetReq <= wrEn && (regIndex == RegResetReq) && wbDatW[0];
            sysRstn  <= ~resetReq;
        end
    end

    // Scratch goes back to zero on either reset
    always_ff @(posedge clk or negedge sysRstn) begin
        if (!sysRstn) begin
            scratch <= 32'b0;
        end else if (wrEn && regIndex == RegScratch) begin
            scratch <= wbDatW;
        end
    end

    always_comb begin
        case (regIndex)
            RegId:      readData = SocId;
            RegScratch: readData = scratch;
            RegIrqRaw:  readData = {31'b0, keyIrq};
            default:    readData = 32'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access) begin
            sysDatR <= readData;
        end
    end

endmodule

`default_nettype wire

// File: hw/wbPeriphSystem.sv
`default_nettype none
`timescale 1ns/1ps

module wbPeriphSystem #(
    parameter int TcmAddrWidth = 10
) (
    input  logic               clk,
    input  logic               RSTn,
    input  logic               wbCyc,
    input  logic               wbStb,
    input  logic               wbWe,
    input  socBusPkg::busAddr_u wbAdr,
    input  socBusPkg::wbSel_t  wbSel,
    input  socBusPkg::wbData_t wbDatW,
    output socBusPkg::wbData_t wbDatR,
    output logic               wbAck,
    output logic               wbErr,
    input  logic               key,
    output logic [3:0]         ledOut,
    output logic               irq
);

    // Registered subsystem reset from the system control block
    logic sysRstn;

    // Decoder to targets
    logic tcmStb;
    logic periphStb;
    socBusPkg::wbData_t tcmDatR;
    socBusPkg::wbData_t periphDatR;
    logic tcmAck;
    logic periphAck;
    logic periphErr;

    // Peripheral slot mux to leaves
    logic gpioStb;
    logic sysStb;
    socBusPkg::wbData_t gpioDatR;
    socBusPkg::wbData_t sysDatR;
    logic gpioAck;
    logic sysAck;

    busDecoder #(
        .TcmAddrWidth (TcmAddrWidth)
    ) busDecoder_inst (
        .clk        (clk),
        .sysRstn    (sysRstn),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbAdr      (wbAdr),
        .tcmStb     (tcmStb),
        .periphStb  (periphStb),
        .tcmDatR    (tcmDatR),
        .periphDatR (periphDatR),
        .tcmAck     (tcmAck),
        .periphAck  (periphAck),
        .periphErr  (periphErr),
        .wbDatR     (wbDatR),
        .wbAck      (wbAck),
        .wbErr      (wbErr)
    );

    tcmSram #(
        .TcmAddrWidth (TcmAddrWidth)
    ) tcmSram_inst (
        .clk     (clk),
        .tcmStb  (tcmStb),
        .wbWe    (wbWe),
        .wbAdr   (wbAdr),
        .wbSel   (wbSel),
        .wbDatW  (wbDatW),
        .tcmDatR (tcmDatR),
        .tcmAck  (tcmAck),
        .sysRstn (sysRstn)
    );

    periphMux periphMux_inst (
        .clk        (clk),
        .sysRstn    (sysRstn),
        .periphStb  (periphStb),
        .wbAdr      (wbAdr),
        .gpioStb    (gpioStb),
        .sysStb     (sysStb),
        .gpioDatR   (gpioDatR),
        .sysDatR    (sysDatR),
        .gpioAck    (gpioAck),
        .sysAck     (sysAck),
        .periphDatR (periphDatR),
        .periphAck  (periphAck),
        .periphErr  (periphErr)
    );

    keyLedGpio keyLedGpio_inst (
        .clk      (clk),
        .sysRstn  (sysRstn),
        .gpioStb  (gpioStb),
        .wbWe     (wbWe),
        .regIndex (wbAdr.periph.regIndex),
        .wbDatW   (wbDatW),
        .gpioDatR (gpioDatR),
        .gpioAck  (gpioAck),
        .key      (key),
        .ledOut   (ledOut),
        .keyIrq   (irq)
    );

    sysControl sysControl_inst (
        .clk      (clk),
        .RSTn     (RSTn),
        .sysStb   (sysStb),
        .wbWe     (wbWe),
        .regIndex (wbAdr.periph.regIndex),
        .wbDatW   (wbDatW),
        .sysDatR  (sysDatR),
        .sysAck   (sysAck),
        .keyIrq   (irq),
        .sysRstn  (sysRstn)
    );

endmodule

`default_nettype wire

// File: test/tbWbPeriphSystem.sv
`default_nettype none
`timescale 1ns/1ps

module tbWbPeriphSystem;
    import socMapPkg::*;

    localparam int TcmAddrWidth = 10;
    localparam int Depth = 2 ** TcmAddrWidth;
    localparam int SramWords = 64;
    localparam int CtrlRequests = 40;
    // Four cycles per request at most plus room for reset and key waits
    localparam int WatchdogCycles = 4 * (3 * SramWords + CtrlRequests) + 1000;

    logic        clk;
    logic        RSTn;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [31:0] wbAdr;
    logic [3:0]  wbSel;
    logic [31:0] wbDatW;
    logic [31:0] wbDatR;
    logic        wbAck;
    logic        wbErr;
    logic        key;
    logic [3:0]  ledOut;
    logic        irq;

    // Reference model state
    logic [31:0] modelMem [Depth];
    int unsigned wordList [SramWords];
    logic [3:0]  modelLed;
    logic        modelEnable;
    logic        modelPending;
    logic        modelIrqQ;
    logic [31:0] modelScratch;
    logic [31:0] rngState;

    // Last bus response
    logic        lastAck;
    logic        lastErr;
    logic [31:0] lastData;
    int          lastLatency;

    string curTest = "reset";
    int testCount = 0;
    int testStartErrors = 0;
    int checkCount = 0;
    int checkFails = 0;
    int bothFails = 0;
    int respFails = 0;
    int ledFails = 0;
    int irqFails = 0;

    wbPeriphSystem #(
        .TcmAddrWidth (TcmAddrWidth)
    ) wbPeriphSystem_inst (
        .clk    (clk),
        .RSTn   (RSTn),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbSel  (wbSel),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck),
        .wbErr  (wbErr),
        .key    (key),
        .ledOut (ledOut),
        .irq    (irq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Interrupt output trails pending and enable by one edge
    always @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            modelIrqQ <= 1'b0;
        end else begin
            modelIrqQ <= modelPending & modelEnable;
        end
    end

    // ------------------------------------------------------------------------
    // Bus protocol and output checks
    // ------------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (!RSTn) !(wbAck && wbErr))
        else begin
            bothFails++;
            $display("%s: wbAck and wbErr were high in the same cycle", curTest);
        end

    assert property (@(posedge clk) disable iff (!RSTn)
        (wbCyc && wbStb && !wbAck && !wbErr) |=> (wbAck || wbErr))
        else begin
            respFails++;
            $display("%s: a request got no response on the next edge", curTest);
        end

    assert property (@(posedge clk) disable iff (!RSTn) ledOut == modelLed)
        else begin
            ledFails++;
            $display("Error %s ledOut: expected %h, actual %h",
                     curTest, $sampled(modelLed), $sampled(ledOut));
        end

    assert property (@(posedge clk) disable iff (!RSTn) irq == modelIrqQ)
        else begin
            irqFails++;
            $display("Error %s irq: expected %b, actual %b",
                     curTest, $sampled(modelIrqQ), $sampled(irq));
        end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    function automatic int totalErrors();
        return checkFails + bothFails + respFails + ledFails + irqFails;
    endfunction

    function automatic logic [31:0] tcmAddr(input int unsigned index);
        return {RegionTcm, index[25:0], 2'b00};
    endfunction

    function automatic logic [31:0] regAddr(input logic [3:0] slot, input logic [9:0] index);
        return {RegionPeriph, 12'h000, slot, index, 2'b00};
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual === expected)
            else begin
                checkFails++;
                $display("Error %s %s: expected %h, actual %h",
                         curTest, what, expected, actual);
            end
    endtask

    // One classic cycle with the strobe held until the next request or busIdle
    task automatic busCycle(input logic we, input logic [31:0] adr,
                            input logic [31:0] dat, input logic [3:0] sel);
        int waited;
        waited = 0;
        @(posedge clk);
        wbCyc  <= 1'b1;
        wbStb  <= 1'b1;
        wbWe   <= we;
        wbAdr  <= adr;
        wbDatW <= dat;
        wbSel  <= sel;
        @(posedge clk);
        lastAck = 1'b0;
        lastErr = 1'b0;
        while (!lastAck && !lastErr && waited < 16) begin
            @(negedge clk);
            waited++;
            lastAck = wbAck;
            lastErr = wbErr;
        end
        lastLatency = waited;
        lastData = wbDatR;
        if (!lastAck && !lastErr) begin
            checkFails++;
            $display("%s: request to address %h was never answered", curTest, adr);
        end
    endtask

    task automatic busIdle();
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe  <= 1'b0;
    endtask

    task automatic wbWrite(input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel);
        busCycle(1'b1, adr, dat, sel);
        checkValue("write ack", 32'd1, {31'b0, lastAck});
    endtask

    task automatic wbRead(input logic [31:0] adr, output logic [31:0] data);
        busCycle(1'b0, adr, 32'h0, 4'hF);
        checkValue("read ack", 32'd1, {31'b0, lastAck});
        data = lastData;
    endtask

    task automatic expectError(input string what);
        checkValue({what, " err"}, 32'd1, {31'b0, lastErr});
        checkValue({what, " ack"}, 32'd0, {31'b0, lastAck});
        checkValue({what, " latency"}, 32'd1, lastLatency);
    endtask

    task automatic startTest(input string name);
        curTest = name;
        testStartErrors = totalErrors();
    endtask

    task automatic endTest();
        busIdle();
        testCount++;
        $display("Test %s: %0d errors", curTest, totalErrors() - testStartErrors);
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic testSramLanes();
        logic [31:0] data;
        logic [31:0] got;
        logic [31:0] r;
        logic [31:0] mask;
        logic [3:0]  sel;
        int unsigned idx;
        startTest("sramLanes");
        // Fill whole words first so every lane is known
        for (int i = 0; i < SramWords; i++) begin
            r = nextRand();
            idx = (r >> 16) % Depth;
            wordList[i] = idx;
            data = nextRand();
            wbWrite(tcmAddr(idx), data, 4'hF);
            modelMem[idx] = data;
        end
        for (int i = 0; i < SramWords; i++) begin
            idx = wordList[i];
            data = nextRand();
            r = nextRand();
            sel = r[7:4];
            wbWrite(tcmAddr(idx), data, sel);
            // Selected bytes come from the write, the rest stay
            mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
            modelMem[idx] = (modelMem[idx] & ~mask) | (data & mask);
        end
        for (int i = 0; i < SramWords; i++) begin
            idx = wordList[i];
            wbRead(tcmAddr(idx), got);
            checkValue("word", modelMem[idx], got);
        end
        endTest();
    endtask

    task automatic testErrors();
        startTest("errors");
        busCycle(1'b0, 32'h3000_0000, 32'h0, 4'hF);
        expectError("region 3");
        busCycle(1'b1, regAddr(4'd5, 10'd0), nextRand(), 4'hF);
        expectError("slot 5");
        busCycle(1'b0, tcmAddr(Depth), 32'h0, 4'hF);
        expectError("TCM limit");
        endTest();
    endtask

    task automatic testLed();
        logic [31:0] r;
        logic [31:0] got;
        startTest("led");
        r = nextRand();
        // Nonzero so the soft reset has something to clear
        if (r[3:0] == 4'h0) begin
            r[3:0] = 4'h9;
        end
        wbWrite(regAddr(SlotGpio, RegLed), r, 4'hF);
        modelLed = r[3:0];
        checkValue("ledOut", {28'b0, modelLed}, {28'b0, ledOut});
        wbRead(regAddr(SlotGpio, RegLed), got);
        checkValue("RegLed", {28'b0, modelLed}, got);
        endTest();
    endtask

    task automatic testKeyIrq();
        logic [31:0] got;
        startTest("keyIrq");
        busIdle();
        key <= 1'b1;
        repeat (4) @(posedge clk);
        modelPending = 1'b1;
        wbRead(regAddr(SlotGpio, RegKeyStatus), got);
        checkValue("status key held", 32'h3, got);
        busIdle();
        key <= 1'b0;
        repeat (4) @(posedge clk);
        wbRead(regAddr(SlotGpio, RegKeyStatus), got);
        checkValue("status key released", 32'h2, got);
        checkValue("irq disabled", 32'd0, {31'b0, irq});
        wbWrite(regAddr(SlotGpio, RegIrqEnable), 32'h1, 4'hF);
        modelEnable = 1'b1;
        wbRead(regAddr(SlotSysCtrl, RegIrqRaw), got);
        checkValue("RegIrqRaw", {31'b0, modelPending & modelEnable}, got);
        checkValue("irq enabled", 32'd1, {31'b0, irq});
        wbWrite(regAddr(SlotGpio, RegIrqClear), 32'h1, 4'hF);
        modelPending = 1'b0;
        busIdle();
        repeat (2) @(posedge clk);
        checkValue("irq cleared", 32'd0, {31'b0, irq});
        wbRead(regAddr(SlotGpio, RegKeyStatus), got);
        checkValue("status cleared", 32'h0, got);
        endTest();
    endtask

    task automatic testSoftReset();
        logic [31:0] got;
        int unsigned idx;
        startTest("softReset");
        wbRead(regAddr(SlotSysCtrl, RegId), got);
        checkValue("RegId", 32'h4D335F31, got);
        modelScratch = nextRand();
        wbWrite(regAddr(SlotSysCtrl, RegScratch), modelScratch, 4'hF);
        wbRead(regAddr(SlotSysCtrl, RegScratch), got);
        checkValue("scratch", modelScratch, got);
        wbWrite(regAddr(SlotGpio, RegIrqEnable), 32'h1, 4'hF);
        modelEnable = 1'b1;
        wbWrite(regAddr(SlotSysCtrl, RegResetReq), 32'h1, 4'hF);
        busIdle();
        // Peripheral state goes to zero while the SRAM keeps its contents
        modelLed = 4'h0;
        modelEnable = 1'b0;
        modelScratch = 32'h0;
        repeat (3) @(posedge clk);
        wbRead(regAddr(SlotSysCtrl, RegScratch), got);
        checkValue("scratch after reset", modelScratch, got);
        wbRead(regAddr(SlotGpio, RegLed), got);
        checkValue("RegLed after reset", {28'b0, modelLed}, got);
        wbRead(regAddr(SlotGpio, RegIrqEnable), got);
        checkValue("enable after reset", {31'b0, modelEnable}, got);
        idx = wordList[0];
        wbRead(tcmAddr(idx), got);
        checkValue("SRAM after reset", modelMem[idx], got);
        endTest();
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        rngState = 32'd83017;
        modelLed = 4'h0;
        modelEnable = 1'b0;
        modelPending = 1'b0;
        modelScratch = 32'h0;
        RSTn   <= 1'b0;
        wbCyc  <= 1'b0;
        wbStb  <= 1'b0;
        wbWe   <= 1'b0;
        wbAdr  <= 32'h0;
        wbSel  <= 4'h0;
        wbDatW <= 32'h0;
        key    <= 1'b0;
        repeat (4) @(posedge clk);
        RSTn <= 1'b1;
        repeat (3) @(posedge clk);
        testSramLanes();
        testErrors();
        testLed();
        testKeyIrq();
        testSoftReset();
        $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, totalErrors());
        if (totalErrors() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Watchdog: the run did not finish within %0d cycles", WatchdogCycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: wbPeriphSystem.f
hw/socBusPkg.sv
hw/socMapPkg.sv
hw/busDecoder.sv
hw/tcmSram.sv
hw/periphMux.sv
hw/keyLedGpio.sv
hw/sysControl.sv
hw/wbPeriphSystem.sv
test/tbWbPeriphSystem.sv

// File: runSim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbWbPeriphSystem \
    -f wbPeriphSystem.f -Mdir obj_dir -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* FAILED \*\*\*" sim.log; then
    exit 1
fi
exit 0
